//--- vlog.f
hdl/zhxpu_pkg.sv
hdl/flash_ctrl.sv
hdl/bootloader.sv
hdl/inst_ram.sv
hdl/register.sv
hdl/alu.sv
hdl/cpu_core.sv
hdl/zhxpu_top.sv
sim/tb_zhxpu.sv

//--- Makefile
TOP = tb_zhxpu

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module zhxpu_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- sim/tb_zhxpu.sv
`default_nettype none
`timescale 1ns/1ns

module tb_zhxpu import zhxpu_pkg::*; ();

	localparam logic [31:0] SEED = 32'hc544_3f2d;
	localparam int RST_CYCLES  = 4;
	localparam int TABLE_ROWS  = 25;
	localparam int RAND_GROUPS = 4;
	localparam int LOOP_N      = 3;
	localparam int PROG_ROWS   = TABLE_ROWS + 5 * RAND_GROUPS + 1;
	localparam int TIMEOUT     = BOOT_WORDS * (FLASH_WAIT + 2) + 2 * PROG_ROWS * LOOP_N + 100;

	// What a row expects on the LED port
	localparam logic [1:0] K_NONE = 2'd0;
	localparam logic [1:0] K_ONE  = 2'd1;
	localparam logic [1:0] K_DOWN = 2'd2;

	typedef struct packed {
		logic [15:0] inst;
		logic [1:0]  kind;
		logic [15:0] exp;
	} row_t;

	logic                clk;
	logic                rst;
	logic [WORD_W-1:0]   flash_data;
	logic [FLASH_AW-1:0] flash_addr;
	logic                flash_ce;
	logic                flash_oe;
	logic                flash_we;
	logic                flash_byte;
	logic                flash_rp;
	logic [WORD_W-1:0]   led;
	logic                led_strobe;
	logic                boot_done;
	logic                halt;

	logic [15:0] flash_mem [BOOT_WORDS];
	row_t        table_rows [TABLE_ROWS];
	logic [15:0] exp_q [$];
	logic [15:0] model_regs [8];
	logic [31:0] lfsr;
	int          cycles = 0;
	int          negs = 0;
	int          strobes = 0;
	int          reads = 0;
	int          ce_run = 0;
	logic        prev_oe = 1'b1;
	logic        prev_done = 1'b0;

	zhxpu_top DUT (
		.raw_clk    (clk),
		.rst        (rst),
		.flash_data (flash_data),
		.flash_addr (flash_addr),
		.flash_ce   (flash_ce),
		.flash_oe   (flash_oe),
		.flash_we   (flash_we),
		.flash_byte (flash_byte),
		.flash_rp   (flash_rp),
		.led        (led),
		.led_strobe (led_strobe),
		.boot_done  (boot_done),
		.halt       (halt)
	);

	// Flash model, word addressed
	assign flash_data = flash_mem[flash_addr[BOOT_CW-1:0]];

	always #10 clk = ~clk;

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [15:0] encode_reg(input op_t op, input int rd, input int rs,
			input int rt);
		return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
	endfunction

	function automatic logic [15:0] encode_imm(input op_t op, input int rd,
			input logic [7:0] imm);
		return {op, 3'(rd), 1'b0, imm};
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic random_byte(output logic [7:0] v);
		v = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	// ISA rules for the ops used in the random block
	task automatic model_step(input logic [15:0] w);
		logic [2:0] rd;
		logic [2:0] rs;
		logic [2:0] rt;
		rd = w[11:9];
		rs = w[8:6];
		rt = w[5:3];
		case (w[15:12])
			op_li:    model_regs[rd] = {8'h00, w[7:0]};
			op_addiu: model_regs[rd] = model_regs[rd] + {{8{w[7]}}, w[7:0]};
			op_addu:  model_regs[rd] = model_regs[rs] + model_regs[rt];
			op_out:   exp_q.push_back(model_regs[rd]);
			default:  ;
		endcase
	endtask

	task automatic build_image();
		logic [15:0] prog [$];
		logic [15:0] grp [5];
		logic [7:0]  x;
		logic [7:0]  y;
		logic [7:0]  z;
		table_rows = '{
			'{encode_imm(op_li, 1, 8'hff), K_NONE, 16'h0000},
			'{encode_imm(op_li, 2, 8'h01), K_NONE, 16'h0000},
			'{encode_reg(op_addu, 3, 1, 2), K_NONE, 16'h0000},
			'{encode_imm(op_out, 3, 8'h00), K_ONE, 16'h0100},
			'{encode_imm(op_addiu, 1, 8'h80), K_NONE, 16'h0000},
			'{encode_imm(op_out, 1, 8'h00), K_ONE, 16'h007f},
			'{encode_reg(op_subu, 5, 2, 1), K_NONE, 16'h0000},
			'{encode_imm(op_out, 5, 8'h00), K_ONE, 16'hff82},
			'{encode_imm(op_addiu, 5, 8'h7e), K_NONE, 16'h0000},
			'{encode_imm(op_out, 5, 8'h00), K_ONE, 16'h0000},
			'{encode_imm(op_li, 6, 8'hf0), K_NONE, 16'h0000},
			'{encode_reg(op_and, 7, 6, 1), K_NONE, 16'h0000},
			'{encode_imm(op_out, 7, 8'h00), K_ONE, 16'h0070},
			'{encode_reg(op_or, 7, 6, 3), K_NONE, 16'h0000},
			'{encode_imm(op_out, 7, 8'h00), K_ONE, 16'h01f0},
			'{encode_reg(op_subu, 4, 0, 2), K_NONE, 16'h0000},
			'{encode_imm(op_out, 4, 8'h00), K_ONE, 16'hffff},
			'{encode_reg(op_addu, 4, 4, 4), K_NONE, 16'h0000},
			'{encode_imm(op_out, 4, 8'h00), K_ONE, 16'hfffe},
			// Count-down loop, one out per trip
			'{encode_imm(op_li, 1, 8'(LOOP_N)), K_NONE, 16'h0000},
			'{encode_imm(op_out, 1, 8'h00), K_DOWN, 16'(LOOP_N)},
			'{encode_imm(op_addiu, 1, 8'hff), K_NONE, 16'h0000},
			'{encode_imm(op_beqz, 1, 8'h01), K_NONE, 16'h0000},
			'{encode_imm(op_b, 0, 8'hfc), K_NONE, 16'h0000},
			'{encode_imm(op_out, 1, 8'h00), K_ONE, 16'h0000}
		};
		foreach (table_rows[i]) begin
			prog.push_back(table_rows[i].inst);
			if (table_rows[i].kind == K_ONE) begin
				exp_q.push_back(table_rows[i].exp);
			end else if (table_rows[i].kind == K_DOWN) begin
				for (int k = int'(table_rows[i].exp); k > 0; k--)
					exp_q.push_back(16'(k));
			end
		end
		for (int g = 0; g < RAND_GROUPS; g++) begin
			random_byte(x);
			random_byte(y);
			random_byte(z);
			grp[0] = encode_imm(op_li, 1, x);
			grp[1] = encode_imm(op_addiu, 1, y);
			grp[2] = encode_imm(op_li, 2, z);
			grp[3] = encode_reg(op_addu, 3, 1, 2);
			grp[4] = encode_imm(op_out, 3, 8'h00);
			foreach (grp[j]) begin
				prog.push_back(grp[j]);
				model_step(grp[j]);
			end
		end
		prog.push_back(encode_imm(op_halt, 0, 8'h00));
		for (int i = 0; i < BOOT_WORDS; i++)
			flash_mem[i] = (i < prog.size()) ? prog[i] : encode_imm(op_halt, 0, 8'h00);
	endtask

	always @(posedge clk) begin
		cycles++;
		assert (cycles < TIMEOUT) else begin
			$display("Timeout after %0d cycles without reaching halt", cycles);
			abort_run();
		end
	end

	// All DUT outputs are sampled on the falling edge
	always @(negedge clk) begin
		negs++;
		if (negs <= RST_CYCLES + 1) begin
			compare_value("boot_done", boot_done, 0);
			compare_value("led_strobe", led_strobe, 0);
			compare_value("halt", halt, 0);
			compare_value("flash_ce", flash_ce, 1);
			compare_value("flash_oe", flash_oe, 1);
		end
		// Read only, word mode, chip released once reset is over
		compare_value("flash_we", flash_we, 1);
		compare_value("flash_byte", flash_byte, 1);
		compare_value("flash_rp", flash_rp, negs > RST_CYCLES);
		compare_value("flash_oe", flash_oe, flash_ce);
		if (!flash_ce) begin
			ce_run++;
		end else if (ce_run != 0) begin
			compare_value("flash_ce low cycles", ce_run, FLASH_WAIT);
			ce_run = 0;
		end
		if (prev_oe && !flash_oe) begin
			compare_value("flash_addr", flash_addr, reads);
			reads++;
		end
		prev_oe = flash_oe;
		if (boot_done && !prev_done)
			compare_value("flash reads at boot_done", reads, BOOT_WORDS);
		if (prev_done)
			compare_value("boot_done", boot_done, 1);
		if (boot_done)
			compare_value("flash_ce", flash_ce, 1);
		prev_done = boot_done;
		if (led_strobe) begin
			assert (strobes < exp_q.size()) else begin
				$display("led_strobe pulsed more often than the program has results");
				abort_run();
			end
			compare_value("led", led, exp_q[strobes]);
			strobes++;
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		lfsr = SEED;
		foreach (model_regs[i])
			model_regs[i] = '0;
		build_image();
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		while (!halt)
			@(negedge clk);
		// Halt must hold and the LED port stay quiet
		repeat (50) begin
			@(negedge clk);
			compare_value("halt", halt, 1);
			compare_value("led_strobe", led_strobe, 0);
		end
		@(posedge clk);
		compare_value("strobe count", strobes, exp_q.size());
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/zhxpu_top.sv
`default_nettype none
`timescale 1ns/1ns

module zhxpu_top import zhxpu_pkg::*; (
	input  wire                 raw_clk,
	input  wire                 rst,
	input  wire  [WORD_W-1:0]   flash_data,
	output logic [FLASH_AW-1:0] flash_addr,
	output logic                flash_ce,
	output logic                flash_oe,
	output logic                flash_we,
	output logic                flash_byte,
	output logic                flash_rp,
	output logic [WORD_W-1:0]   led,
	output logic                led_strobe,
	output logic                boot_done,
	output logic                halt
);

	// Boot path
	logic                read_req;
	logic [FLASH_AW-1:0] read_addr;
	logic [WORD_W-1:0]   flash_word;
	logic                data_valid;
	logic                ram_we;
	logic [RAM_AW-1:0]   ram_waddr;
	logic [WORD_W-1:0]   ram_wdata;

	// Fetch path
	logic [RAM_AW-1:0]   fetch_addr;
	logic [WORD_W-1:0]   fetch_data;

	flash_ctrl __flash_ctrl (
		.raw_clk    (raw_clk),
		.rst        (rst),
		.read_req   (read_req),
		.read_addr  (read_addr),
		.flash_data (flash_data),
		.flash_addr (flash_addr),
		.flash_ce   (flash_ce),
		.flash_oe   (flash_oe),
		.flash_we   (flash_we),
		.flash_byte (flash_byte),
		.flash_rp   (flash_rp),
		.data       (flash_word),
		.data_valid (data_valid)
	);

	bootloader __bootloader (
		.raw_clk    (raw_clk),
		.rst        (rst),
		.data       (flash_word),
		.data_valid (data_valid),
		.read_req   (read_req),
		.read_addr  (read_addr),
		.ram_we     (ram_we),
		.ram_waddr  (ram_waddr),
		.ram_wdata  (ram_wdata),
		.boot_done  (boot_done)
	);

	inst_ram __inst_ram (
		.raw_clk (raw_clk),
		.we      (ram_we),
		.waddr   (ram_waddr),
		.wdata   (ram_wdata),
		.raddr   (fetch_addr),
		.rdata   (fetch_data)
	);

	cpu_core __cpu_core (
		.raw_clk    (raw_clk),
		.rst        (rst),
		.boot_done  (boot_done),
		.fetch_addr (fetch_addr),
		.fetch_data (fetch_data),
		.led        (led),
		.led_strobe (led_strobe),
		.halt       (halt)
	);

endmodule

`default_nettype wire

//--- hdl/cpu_core.sv
`default_nettype none
`timescale 1ns/1ns

module cpu_core import zhxpu_pkg::*; (
	input  wire                raw_clk,
	input  wire                rst,
	input  wire                boot_done,
	output logic [RAM_AW-1:0]  fetch_addr,
	input  wire  [WORD_W-1:0]  fetch_data,
	output logic [WORD_W-1:0]  led,
	output logic               led_strobe,
	output logic               halt
);

	logic              exec;
	logic [RAM_AW-1:0] pc;
	logic [RAM_AW-1:0] branch_off;
	inst_u             inst;
	op_t               op;
	logic              writes_reg;
	logic              reads_rs;
	logic              take_branch;
	logic              is_out;
	logic              is_stop;
	logic              reg_we;
	logic [REG_AW-1:0] raddr1;
	logic [WORD_W-1:0] rdata1;
	logic [WORD_W-1:0] rdata2;
	logic [WORD_W-1:0] alu_res;
	logic              alu_zero;

	assign inst       = fetch_data;
	assign op         = inst.r_fmt.op;
	assign fetch_addr = pc;
	assign branch_off = RAM_AW'(signed'(inst.i_fmt.imm8));

	always_comb begin
		writes_reg  = 1'b0;
		reads_rs    = 1'b0;
		take_branch = 1'b0;
		is_out      = 1'b0;
		is_stop     = 1'b0;
		case (op)
			op_addu, op_subu, op_and, op_or: begin
				writes_reg = 1'b1;
				reads_rs   = 1'b1;
			end
			op_li, op_addiu: writes_reg  = 1'b1;
			op_beqz:         take_branch = alu_zero;
			op_b:            take_branch = 1'b1;
			op_out:          is_out      = 1'b1;
			// Unknown codes stop like halt
			default:         is_stop     = 1'b1;
		endcase
	end

	// Immediate ops and out work on rd
	assign raddr1 = reads_rs ? inst.r_fmt.rs : inst.r_fmt.rd;
	assign reg_we = exec && writes_reg;

	register __register (
		.raw_clk (raw_clk),
		.rst     (rst),
		.we      (reg_we),
		.waddr   (inst.r_fmt.rd),
		.wdata   (alu_res),
		.raddr1  (raddr1),
		.raddr2  (inst.r_fmt.rt),
		.rdata1  (rdata1),
		.rdata2  (rdata2)
	);

	alu __alu (
		.op   (op),
		.a    (rdata1),
		.b    (rdata2),
		.imm  (inst.i_fmt.imm8),
		.res  (alu_res),
		.zero (alu_zero)
	);

	always_ff @(posedge raw_clk) begin
		if (rst) begin
			exec       <= 1'b0;
			pc         <= '0;
			led        <= '0;
			led_strobe <= 1'b0;
			halt       <= 1'b0;
		end else begin
			led_strobe <= 1'b0;
			if (!exec) begin
				// Held at address 0 until the image is loaded
				if (boot_done && !halt)
					exec <= 1'b1;
			end else begin
				exec <= 1'b0;
				if (is_stop)
					halt <= 1'b1;
				else if (take_branch)
					pc <= pc + 1'b1 + branch_off;
				else
					pc <= pc + 1'b1;
				if (is_out) begin
					led        <= rdata1;
					led_strobe <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`default_nettype none
`timescale 1ns/1ns

module alu import zhxpu_pkg::*; (
	input  wire op_t           op,
	input  wire  [WORD_W-1:0]  a,
	input  wire  [WORD_W-1:0]  b,
	input  wire  [7:0]         imm,
	output logic [WORD_W-1:0]  res,
	output logic               zero
);

	logic [WORD_W-1:0] imm_sx;

	assign imm_sx = WORD_W'(signed'(imm));

	always_comb begin
		case (op)
			op_addu:  res = a + b;
			op_subu:  res = a - b;
			op_and:   res = a & b;
			op_or:    res = a | b;
			op_li:    res = WORD_W'(imm);
			op_addiu: res = a + imm_sx;
			// Pass a through for branch and output
			default:  res = a;
		endcase
	end

	assign zero = (a == '0);

endmodule

`default_nettype wire

//--- hdl/register.sv
`default_nettype none
`timescale 1ns/1ns

module register import zhxpu_pkg::*; (
	input  wire                raw_clk,
	input  wire                rst,
	input  wire                we,
	input  wire  [REG_AW-1:0]  waddr,
	input  wire  [WORD_W-1:0]  wdata,
	input  wire  [REG_AW-1:0]  raddr1,
	input  wire  [REG_AW-1:0]  raddr2,
	output logic [WORD_W-1:0]  rdata1,
	output logic [WORD_W-1:0]  rdata2
);

	logic [WORD_W-1:0] regs [2**REG_AW];

	always_ff @(posedge raw_clk) begin
		if (rst) begin
			for (int i = 0; i < 2**REG_AW; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

//--- hdl/inst_ram.sv
`default_nettype none
`timescale 1ns/1ns

module inst_ram import zhxpu_pkg::*; (
	input  wire                raw_clk,
	input  wire                we,
	input  wire  [RAM_AW-1:0]  waddr,
	input  wire  [WORD_W-1:0]  wdata,
	input  wire  [RAM_AW-1:0]  raddr,
	output logic [WORD_W-1:0]  rdata
);

	logic [WORD_W-1:0] mem [2**RAM_AW];

	always_ff @(posedge raw_clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Registered read, one cycle behind the address
	always_ff @(posedge raw_clk) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

//--- hdl/bootloader.sv
`default_nettype none
`timescale 1ns/1ns

module bootloader import zhxpu_pkg::*; (
	input  wire                 raw_clk,
	input  wire                 rst,
	input  wire  [WORD_W-1:0]   data,
	input  wire                 data_valid,
	output logic                read_req,
	output logic [FLASH_AW-1:0] read_addr,
	output logic                ram_we,
	output logic [RAM_AW-1:0]   ram_waddr,
	output logic [WORD_W-1:0]   ram_wdata,
	output logic                boot_done
);

	logic [1:0]         state;
	logic [BOOT_CW-1:0] word_cnt;

	// Flash word n lands at RAM word n
	assign read_req  = (state == BL_REQ);
	assign read_addr = FLASH_AW'(word_cnt);
	assign ram_we    = (state == BL_WAIT) && data_valid;
	assign ram_waddr = RAM_AW'(word_cnt);
	assign ram_wdata = data;
	assign boot_done = (state == BL_DONE);

	always_ff @(posedge raw_clk) begin
		if (rst) begin
			state    <= BL_IDLE;
			word_cnt <= '0;
		end else begin
			case (state)
				BL_IDLE: state <= BL_REQ;
				BL_REQ:  state <= BL_WAIT;
				BL_WAIT: begin
					if (data_valid) begin
						if (word_cnt == BOOT_CW'(BOOT_WORDS - 1)) begin
							state <= BL_DONE;
						end else begin
							word_cnt <= word_cnt + 1'b1;
							state    <= BL_REQ;
						end
					end
				end
				// Stays here until the next reset
				default: state <= BL_DONE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/flash_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

module flash_ctrl import zhxpu_pkg::*; (
	input  wire                 raw_clk,
	input  wire                 rst,
	input  wire                 read_req,
	input  wire  [FLASH_AW-1:0] read_addr,
	input  wire  [WORD_W-1:0]   flash_data,
	output logic [FLASH_AW-1:0] flash_addr,
	output logic                flash_ce,
	output logic                flash_oe,
	output logic                flash_we,
	output logic                flash_byte,
	output logic                flash_rp,
	output logic [WORD_W-1:0]   data,
	output logic                data_valid
);

	logic [1:0]          state;
	logic [FLASH_CW-1:0] wait_cnt;
	logic                sample;

	// Read only, word wide
	assign flash_we   = 1'b1;
	assign flash_byte = 1'b1;

	assign sample = (state == FL_WAIT) && (wait_cnt == FLASH_CW'(FLASH_WAIT - 2));

	always_ff @(posedge raw_clk) begin
		if (rst) begin
			state      <= FL_IDLE;
			wait_cnt   <= '0;
			flash_addr <= '0;
			flash_ce   <= 1'b1;
			flash_oe   <= 1'b1;
			flash_rp   <= 1'b0;
			data_valid <= 1'b0;
		end else begin
			flash_rp   <= 1'b1;
			data_valid <= 1'b0;
			case (state)
				FL_IDLE: begin
					if (read_req) begin
						flash_addr <= read_addr;
						flash_ce   <= 1'b0;
						flash_oe   <= 1'b0;
						state      <= FL_ACCESS;
					end
				end
				FL_ACCESS: begin
					wait_cnt <= '0;
					state    <= FL_WAIT;
				end
				FL_WAIT: begin
					if (sample) begin
						flash_ce   <= 1'b1;
						flash_oe   <= 1'b1;
						data_valid <= 1'b1;
						state      <= FL_IDLE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				default: state <= FL_IDLE;
			endcase
		end
	end

	// Capture while the chip still drives the bus
	always_ff @(posedge raw_clk) begin
		if (sample)
			data <= flash_data;
	end

endmodule

`default_nettype wire

//--- hdl/zhxpu_pkg.sv
`default_nettype none

package zhxpu_pkg;

	localparam int WORD_W     = 16;
	localparam int RAM_AW     = 8;
	localparam int FLASH_AW   = 23;
	localparam int REG_AW     = 3;
	localparam int BOOT_WORDS = 64;
	localparam int BOOT_CW    = $clog2(BOOT_WORDS);
	localparam int FLASH_WAIT = 3;
	localparam int FLASH_CW   = $clog2(FLASH_WAIT);

	// Flash controller states
	localparam logic [1:0] FL_IDLE   = 2'd0;
	localparam logic [1:0] FL_ACCESS = 2'd1;
	localparam logic [1:0] FL_WAIT   = 2'd2;

	// Bootloader states
	localparam logic [1:0] BL_IDLE = 2'd0;
	localparam logic [1:0] BL_REQ  = 2'd1;
	localparam logic [1:0] BL_WAIT = 2'd2;
	localparam logic [1:0] BL_DONE = 2'd3;

	typedef enum logic [3:0] {
		op_addu  = 4'h0,
		op_subu  = 4'h1,
		op_and   = 4'h2,
		op_or    = 4'h3,
		op_li    = 4'h4,
		op_addiu = 4'h5,
		op_beqz  = 4'h6,
		op_b     = 4'h7,
		op_out   = 4'h8,
		op_halt  = 4'hf
	} op_t;

	// Register form and immediate form of one word
	typedef union packed {
		struct packed {
			op_t               op;
			logic [REG_AW-1:0] rd;
			logic [REG_AW-1:0] rs;
			logic [REG_AW-1:0] rt;
			logic [2:0]        pad;
		} r_fmt;
		struct packed {
			op_t               op;
			logic [REG_AW-1:0] rd;
			logic              pad;
			logic [7:0]        imm8;
		} i_fmt;
	} inst_u;

endpackage

`default_nettype wire
